//--- filelist.f
rtl/adv_regs_pkg.sv
rtl/cfg_ctrl_pkg.sv
rtl/adv_cfg_table.sv
rtl/hdmi_int_tracker.sv
rtl/adv_cfg_sequencer.sv
rtl/adv_cfg_top.sv
tb/adv_cfg_checker.sv
tb/tb_adv_cfg.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with verilator, then scan the log
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
    --top-module tb_adv_cfg -Mdir obj_dir -o sim_adv_cfg
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_adv_cfg > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$log"; then
    exit 1
fi
exit 0

//--- tb/tb_adv_cfg.sv
module tb_adv_cfg
    import adv_regs_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic       clk;
    logic       reset;
    logic       hdmi_int;
    reg_data_t  reg_17_value;
    reg_data_t  reg_3b_value;
    reg_data_t  reg_3c_value;
    logic       req_valid;
    logic       req_ready;
    logic       req_is_read;
    reg_addr_t  req_addr;
    reg_data_t  req_value;
    logic       rsp_valid;
    reg_data_t  rsp_data;
    logic       rsp_ack_error;
    logic       ready;
    int         error_count;
    int         txn_count;
    int         lock_count;
    int         tb_errors;
    int         pll_reads;
    logic       nack_sent;
    logic [7:0] lfsr_state;

    adv_cfg_top dut (.*);

    adv_cfg_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois lfsr, x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    // one lfsr step for each bit taken
    task automatic draw_bits(input int n, output int value);
        int i;
        value = 0;
        for (i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic wait_ready(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (ready !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > 4000) begin
                abort_run({"timeout waiting for ", what});
            end
        end
    endtask

    // i2c master stand-in with random stalls and response delays
    initial begin : bus_model
        int        stall;
        int        delay;
        int        cycles;
        logic      is_read;
        reg_addr_t addr;
        @(posedge reset);
        forever begin
            cycles = 0;
            while (!req_valid) begin
                @(negedge clk);
                cycles++;
                if (cycles > 4000) begin
                    abort_run("timeout waiting for a request from the DUT");
                end
            end
            draw_bits(2, stall);
            repeat (stall) @(negedge clk);
            req_ready = 1'b1;
            is_read   = req_is_read;
            addr      = req_addr;
            @(negedge clk);
            req_ready = 1'b0;
            draw_bits(3, delay);
            repeat (delay) @(negedge clk);
            rsp_valid = 1'b1;
            rsp_data  = '0;
            if (is_read) begin
                // first pll status read reports unlocked
                rsp_data[pll_lock_bit] = (pll_reads > 0);
                pll_reads++;
            end else if (addr == pr_mode_addr && !nack_sent) begin
                rsp_ack_error = 1'b1;
                nack_sent     = 1'b1;
            end
            @(negedge clk);
            rsp_valid     = 1'b0;
            rsp_ack_error = 1'b0;
        end
    end

    initial begin
        reset         = 1'b0;
        hdmi_int      = 1'b1;
        reg_17_value  = 8'h02;
        reg_3b_value  = 8'hD8;
        reg_3c_value  = 8'h10;
        req_ready     = 1'b0;
        rsp_valid     = 1'b0;
        rsp_data      = '0;
        rsp_ack_error = 1'b0;
        lfsr_state    = 8'd94;
        pll_reads     = 0;
        nack_sent     = 1'b0;
        tb_errors     = 0;
        repeat (16) @(negedge clk);
        reset = 1'b1;
        wait_ready(1'b1, "ready after the first configuration");

        // two falling edges of hdmi_int while ready is high
        hdmi_int = 1'b0;
        @(negedge clk);
        hdmi_int = 1'b1;
        @(negedge clk);
        hdmi_int = 1'b0;
        @(negedge clk);
        hdmi_int = 1'b1;
        wait_ready(1'b0, "ready to drop after the first interrupt");
        wait_ready(1'b1, "ready after the first reconfiguration");
        wait_ready(1'b0, "ready to drop for the second interrupt");
        wait_ready(1'b1, "ready after the second reconfiguration");
        repeat (40) begin
            @(negedge clk);
            if (!ready) begin
                tb_errors++;
                $display("ERROR %0t: ready dropped with no interrupt pending", $time);
            end
        end
        if (txn_count != 113 || lock_count != 3) begin
            tb_errors++;
            $display("ERROR %0t: %0d transfers and %0d locks, expected 113 and 3",
                     $time, txn_count, lock_count);
        end
        $display("checker errors %0d, testbench errors %0d, transfers %0d, pll locks %0d",
                 error_count, tb_errors, txn_count, lock_count);
        if (error_count == 0 && tb_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- tb/adv_cfg_checker.sv
module adv_cfg_checker
    import adv_regs_pkg::*, cfg_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_data_t reg_17_value,
    input  reg_data_t reg_3b_value,
    input  reg_data_t reg_3c_value,
    input  logic      req_valid,
    input  logic      req_ready,
    input  logic      req_is_read,
    input  reg_addr_t req_addr,
    input  reg_data_t req_value,
    input  logic      rsp_valid,
    input  reg_data_t rsp_data,
    input  logic      rsp_ack_error,
    input  logic      ready,
    output int        error_count,
    output int        txn_count,
    output int        lock_count
);
    timeunit 1ns;
    timeprecision 1ps;

    cfg_phase_t  exp_phase;
    int          exp_step;
    logic        owed;
    logic        retry;
    logic        held;
    logic        ready_due;
    logic        ready_prev;
    logic [16:0] held_txn;
    logic [16:0] last_txn;
    logic [16:0] exp_txn;
    logic [16:0] seen_txn;

    // {is_read, addr, value} of one entry of the register table
    function automatic logic [16:0] expected_txn(input cfg_phase_t phase, input int step,
            input reg_data_t v17, input reg_data_t v3b, input reg_data_t v3c);
        logic [16:0] t;
        t = '0;
        if (phase == phase_pll_check) begin
            t = {1'b1, pll_status_addr, 8'h00};
        end else if (phase == phase_bootstrap) begin
            case (step)
                0:  t = {1'b0, 8'h41, pwr_ctrl_val};
                1:  t = {1'b0, 8'h98, fixed_98_val};
                2:  t = {1'b0, 8'h9A, fixed_9a_val};
                3:  t = {1'b0, 8'h9C, fixed_9c_val};
                4:  t = {1'b0, 8'h9D, fixed_9d_val};
                5:  t = {1'b0, 8'hA2, fixed_a2_val};
                6:  t = {1'b0, 8'hA3, fixed_a3_val};
                7:  t = {1'b0, 8'hE0, fixed_e0_val};
                8:  t = {1'b0, 8'hF9, fixed_f9_val};
                9:  t = {1'b0, 8'h94, int_enable_val};
                10: t = {1'b0, 8'h96, int_clear_val};
                default: t = '1;
            endcase
        end else begin
            case (step)
                0:  t = {1'b0, 8'h15, input_id_val};
                1:  t = {1'b0, vid_cfg_addr, v17};
                2:  t = {1'b0, 8'h16, output_fmt_val};
                3:  t = {1'b0, 8'h55, avi_info_val};
                4:  t = {1'b0, 8'h18, csc_ctrl_val};
                5:  t = {1'b0, 8'hAF, hdmi_mode_val};
                6:  t = {1'b0, 8'hBA, clk_delay_val};
                7:  t = {1'b0, 8'h0A, audio_sel_val};
                8:  t = {1'b0, 8'h01, acr_n_hi_val};
                9:  t = {1'b0, 8'h02, acr_n_mid_val};
                10: t = {1'b0, 8'h03, acr_n_lo_val};
                11: t = {1'b0, 8'h0B, spdif_ctrl_val};
                12: t = {1'b0, 8'h0C, i2s_ctrl_val};
                13: t = {1'b0, 8'h0D, i2s_width_val};
                14: t = {1'b0, pr_mode_addr, v3b};
                15: t = {1'b0, vic_addr, v3c};
                default: t = '1;
            endcase
        end
        return t;
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            exp_phase   = phase_bootstrap;
            exp_step    = 0;
            owed        = 1'b0;
            retry       = 1'b0;
            held        = 1'b0;
            ready_due   = 1'b0;
            ready_prev  = 1'b0;
            last_txn    = '0;
            error_count = 0;
            txn_count   = 0;
            lock_count  = 0;
        end else begin
            seen_txn = {req_is_read, req_addr, req_value};
            if (held && (!req_valid || seen_txn != held_txn)) begin
                report_error("request dropped or changed before its transfer");
            end
            if (req_valid && owed) begin
                report_error("request issued while a response is still owed");
            end
            if (req_valid && exp_phase == phase_idle) begin
                report_error("request issued while idle");
            end
            if (ready_due && !ready) begin
                report_error("ready not high 1 cycle after the locked pll read");
            end
            if (ready && exp_phase != phase_idle) begin
                report_error("ready high during configuration");
            end
            ready_due = 1'b0;
            // a served interrupt drops ready and restarts at bootstrap step 0
            if (exp_phase == phase_idle && ready_prev && !ready) begin
                exp_phase = phase_bootstrap;
                exp_step  = 0;
            end

            if (req_valid && req_ready) begin
                // a nacked transfer has to come back exactly as it went out
                if (retry) begin
                    exp_txn = last_txn;
                end else begin
                    exp_txn = expected_txn(exp_phase, exp_step, reg_17_value,
                                           reg_3b_value, reg_3c_value);
                end
                // value field of a read carries nothing
                if (exp_txn[16]) begin
                    seen_txn[7:0] = exp_txn[7:0];
                end
                if (seen_txn !== exp_txn) begin
                    error_count++;
                    $display("ERROR %0t: transfer %0d is %h, expected %h",
                             $time, txn_count, seen_txn, exp_txn);
                end
                last_txn = seen_txn;
                owed     = 1'b1;
                retry    = 1'b0;
                txn_count++;
            end
            held     = req_valid && !req_ready;
            held_txn = {req_is_read, req_addr, req_value};

            if (rsp_valid) begin
                if (!owed) begin
                    report_error("response without an outstanding request");
                end
                owed = 1'b0;
                if (rsp_ack_error) begin
                    retry = 1'b1;
                end else if (exp_phase == phase_pll_check) begin
                    if (rsp_data[pll_lock_bit]) begin
                        exp_phase = phase_idle;
                        ready_due = 1'b1;
                        lock_count++;
                    end else begin
                        exp_phase = phase_bootstrap;
                    end
                    exp_step = 0;
                end else if (exp_phase == phase_bootstrap && exp_step == bootstrap_len - 1) begin
                    exp_phase = phase_init;
                    exp_step  = 0;
                end else if (exp_phase == phase_init && exp_step == init_len - 1) begin
                    exp_phase = phase_pll_check;
                    exp_step  = 0;
                end else begin
                    exp_step++;
                end
            end
            ready_prev = ready;
        end
    end

endmodule

//--- rtl/adv_cfg_top.sv
module adv_cfg_top
    import adv_regs_pkg::*, cfg_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      hdmi_int,
    input  reg_data_t reg_17_value,
    input  reg_data_t reg_3b_value,
    input  reg_data_t reg_3c_value,
    output logic      req_valid,
    input  logic      req_ready,
    output logic      req_is_read,
    output reg_addr_t req_addr,
    output reg_data_t req_value,
    input  logic      rsp_valid,
    input  reg_data_t rsp_data,
    input  logic      rsp_ack_error,
    output logic      ready
);

    cfg_phase_t cfg_phase;
    step_t      cfg_step;
    reg_addr_t  tbl_addr;
    reg_data_t  tbl_value;
    logic       tbl_is_read;
    logic       tbl_last;
    logic       int_pending;
    logic       int_take;

    adv_cfg_table u_table (
        .cfg_phase    (cfg_phase),
        .cfg_step     (cfg_step),
        .reg_17_value (reg_17_value),
        .reg_3b_value (reg_3b_value),
        .reg_3c_value (reg_3c_value),
        .tbl_addr     (tbl_addr),
        .tbl_value    (tbl_value),
        .tbl_is_read  (tbl_is_read),
        .tbl_last     (tbl_last)
    );

    hdmi_int_tracker u_tracker (
        .clk         (clk),
        .reset       (reset),
        .hdmi_int    (hdmi_int),
        .int_take    (int_take),
        .int_pending (int_pending)
    );

    adv_cfg_sequencer u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .tbl_addr      (tbl_addr),
        .tbl_value     (tbl_value),
        .tbl_is_read   (tbl_is_read),
        .tbl_last      (tbl_last),
        .int_pending   (int_pending),
        .cfg_phase     (cfg_phase),
        .cfg_step      (cfg_step),
        .int_take      (int_take),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_is_read   (req_is_read),
        .req_addr      (req_addr),
        .req_value     (req_value),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .rsp_ack_error (rsp_ack_error),
        .ready         (ready)
    );

endmodule

//--- rtl/adv_cfg_sequencer.sv
module adv_cfg_sequencer
    import adv_regs_pkg::*, cfg_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  reg_addr_t  tbl_addr,
    input  reg_data_t  tbl_value,
    input  logic       tbl_is_read,
    input  logic       tbl_last,
    input  logic       int_pending,
    output cfg_phase_t cfg_phase,
    output step_t      cfg_step,
    output logic       int_take,
    output logic       req_valid,
    input  logic       req_ready,
    output logic       req_is_read,
    output reg_addr_t  req_addr,
    output reg_data_t  req_value,
    input  logic       rsp_valid,
    input  reg_data_t  rsp_data,
    input  logic       rsp_ack_error,
    output logic       ready
);

    bus_state_t bus_state;
    cfg_phase_t adv_phase;
    step_t      adv_step;
    logic       pll_locked;
    logic       load_req;
    logic       retry_req;

    // phase and step point at the table entry that is loaded next,
    // so the request register alone holds the outstanding transaction
    always_comb begin
        adv_phase = cfg_phase;
        adv_step  = cfg_step + step_t'(1);
        if (tbl_last) begin
            adv_step = '0;
            case (cfg_phase)
                phase_bootstrap: adv_phase = phase_init;
                phase_init:      adv_phase = phase_pll_check;
                // after the pll read the failure path is assumed
                default:         adv_phase = phase_bootstrap;
            endcase
        end
    end

    // the pll status read is the only read in the table
    assign pll_locked = req_is_read && rsp_data[pll_lock_bit];

    assign retry_req = (bus_state == bus_wait_rsp) && rsp_valid && rsp_ack_error;

    assign load_req = ((bus_state == bus_next) && (cfg_phase != phase_idle))
                   || ((bus_state == bus_wait_rsp) && rsp_valid && !rsp_ack_error
                       && !pll_locked);

    // one pending interrupt is served per pass through idle
    assign int_take = (bus_state == bus_next) && (cfg_phase == phase_idle) && int_pending;

    always_ff @(posedge clk) begin
        if (load_req) begin
            req_is_read <= tbl_is_read;
            req_addr    <= tbl_addr;
            req_value   <= tbl_value;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            cfg_phase <= phase_bootstrap;
            cfg_step  <= '0;
            bus_state <= bus_next;
            req_valid <= 1'b0;
            ready     <= 1'b0;
        end else begin
            case (bus_state)
                bus_next: begin
                    if (int_take) begin
                        ready     <= 1'b0;
                        cfg_phase <= phase_bootstrap;
                        cfg_step  <= '0;
                    end
                end
                bus_issue: begin
                    if (req_ready) begin
                        req_valid <= 1'b0;
                        bus_state <= bus_wait_rsp;
                    end
                end
                bus_wait_rsp: begin
                    if (rsp_valid && !rsp_ack_error && pll_locked) begin
                        ready     <= 1'b1;
                        cfg_phase <= phase_idle;
                        cfg_step  <= '0;
                        bus_state <= bus_next;
                    end
                end
                default: bus_state <= bus_next;
            endcase

            // nacked transaction goes out again with the same payload
            if (retry_req) begin
                req_valid <= 1'b1;
                bus_state <= bus_issue;
            end

            if (load_req) begin
                req_valid <= 1'b1;
                bus_state <= bus_issue;
                cfg_phase <= adv_phase;
                cfg_step  <= adv_step;
            end
        end
    end

endmodule

//--- rtl/hdmi_int_tracker.sv
module hdmi_int_tracker
    import adv_regs_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic hdmi_int,
    input  logic int_take,
    output logic int_pending
);

    logic       int_sync;
    logic       int_prev;
    logic       int_fall;
    int_count_t int_count;

    // input register, then the previous value for the edge compare
    always_ff @(posedge clk) begin
        if (!reset) begin
            int_sync <= 1'b1;
            int_prev <= 1'b1;
        end else begin
            int_sync <= hdmi_int;
            int_prev <= int_sync;
        end
    end

    // hdmi_int is active low
    assign int_fall = int_prev && !int_sync;

    // an edge and a take in the same cycle leave the count alone
    always_ff @(posedge clk) begin
        if (!reset) begin
            int_count <= '0;
        end else if (int_fall && !int_take) begin
            if (int_count != '1) begin
                int_count <= int_count + int_count_t'(1);
            end
        end else if (int_take && !int_fall) begin
            if (int_count != '0) begin
                int_count <= int_count - int_count_t'(1);
            end
        end
    end

    assign int_pending = (int_count != '0);

endmodule

//--- rtl/adv_cfg_table.sv
module adv_cfg_table
    import adv_regs_pkg::*, cfg_ctrl_pkg::*;
(
    input  cfg_phase_t cfg_phase,
    input  step_t      cfg_step,
    input  reg_data_t  reg_17_value,
    input  reg_data_t  reg_3b_value,
    input  reg_data_t  reg_3c_value,
    output reg_addr_t  tbl_addr,
    output reg_data_t  tbl_value,
    output logic       tbl_is_read,
    output logic       tbl_last
);

    always_comb begin
        tbl_addr    = '0;
        tbl_value   = '0;
        tbl_is_read = 1'b0;
        tbl_last    = 1'b0;
        case (cfg_phase)
            phase_bootstrap: begin
                tbl_last = (cfg_step == step_t'(bootstrap_len - 1));
                case (cfg_step)
                    5'd0:  {tbl_addr, tbl_value} = {8'h41, pwr_ctrl_val};
                    5'd1:  {tbl_addr, tbl_value} = {8'h98, fixed_98_val};
                    5'd2:  {tbl_addr, tbl_value} = {8'h9A, fixed_9a_val};
                    5'd3:  {tbl_addr, tbl_value} = {8'h9C, fixed_9c_val};
                    5'd4:  {tbl_addr, tbl_value} = {8'h9D, fixed_9d_val};
                    5'd5:  {tbl_addr, tbl_value} = {8'hA2, fixed_a2_val};
                    5'd6:  {tbl_addr, tbl_value} = {8'hA3, fixed_a3_val};
                    5'd7:  {tbl_addr, tbl_value} = {8'hE0, fixed_e0_val};
                    5'd8:  {tbl_addr, tbl_value} = {8'hF9, fixed_f9_val};
                    5'd9:  {tbl_addr, tbl_value} = {8'h94, int_enable_val};
                    5'd10: {tbl_addr, tbl_value} = {8'h96, int_clear_val};
                    default: ;
                endcase
            end
            phase_init: begin
                tbl_last = (cfg_step == step_t'(init_len - 1));
                case (cfg_step)
                    5'd0:  {tbl_addr, tbl_value} = {8'h15, input_id_val};
                    // sync polarity and aspect ratio follow the video mode
                    5'd1:  {tbl_addr, tbl_value} = {vid_cfg_addr, reg_17_value};
                    5'd2:  {tbl_addr, tbl_value} = {8'h16, output_fmt_val};
                    5'd3:  {tbl_addr, tbl_value} = {8'h55, avi_info_val};
                    5'd4:  {tbl_addr, tbl_value} = {8'h18, csc_ctrl_val};
                    5'd5:  {tbl_addr, tbl_value} = {8'hAF, hdmi_mode_val};
                    5'd6:  {tbl_addr, tbl_value} = {8'hBA, clk_delay_val};
                    5'd7:  {tbl_addr, tbl_value} = {8'h0A, audio_sel_val};
                    5'd8:  {tbl_addr, tbl_value} = {8'h01, acr_n_hi_val};
                    5'd9:  {tbl_addr, tbl_value} = {8'h02, acr_n_mid_val};
                    5'd10: {tbl_addr, tbl_value} = {8'h03, acr_n_lo_val};
                    5'd11: {tbl_addr, tbl_value} = {8'h0B, spdif_ctrl_val};
                    5'd12: {tbl_addr, tbl_value} = {8'h0C, i2s_ctrl_val};
                    5'd13: {tbl_addr, tbl_value} = {8'h0D, i2s_width_val};
                    // pixel repetition and vic of the current mode
                    5'd14: {tbl_addr, tbl_value} = {pr_mode_addr, reg_3b_value};
                    5'd15: {tbl_addr, tbl_value} = {vic_addr, reg_3c_value};
                    default: ;
                endcase
            end
            phase_pll_check: begin
                // single read, the value field is unused
                tbl_addr    = pll_status_addr;
                tbl_is_read = 1'b1;
                tbl_last    = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- rtl/cfg_ctrl_pkg.sv
package cfg_ctrl_pkg;

    // which block of the configuration is being walked
    typedef enum logic [1:0] {
        phase_bootstrap,
        phase_init,
        phase_pll_check,
        phase_idle
    } cfg_phase_t;

    // request channel handshake
    // next loads a table entry, issue waits for the transfer,
    // wait_rsp waits for the response strobe
    typedef enum logic [1:0] {
        bus_issue,
        bus_wait_rsp,
        bus_next
    } bus_state_t;

endpackage

//--- rtl/adv_regs_pkg.sv
package adv_regs_pkg;

    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;
    typedef logic [4:0] step_t;
    typedef logic [7:0] int_count_t;

    localparam int bootstrap_len = 11;
    localparam int init_len      = 16;

    // pll status register, bit 4 set once the pll is locked
    localparam reg_addr_t pll_status_addr = 8'h9E;
    localparam int        pll_lock_bit    = 4;

    // registers whose value comes from the video mode inputs
    localparam reg_addr_t vid_cfg_addr = 8'h17;
    localparam reg_addr_t pr_mode_addr = 8'h3B;
    localparam reg_addr_t vic_addr     = 8'h3C;

    // bootstrap: power up, fixed registers, interrupt setup
    localparam reg_data_t pwr_ctrl_val   = 8'h10;
    localparam reg_data_t fixed_98_val   = 8'h03;
    localparam reg_data_t fixed_9a_val   = 8'hE0;
    localparam reg_data_t fixed_9c_val   = 8'h30;
    localparam reg_data_t fixed_9d_val   = 8'h01;
    localparam reg_data_t fixed_a2_val   = 8'hA4;
    localparam reg_data_t fixed_a3_val   = 8'hA4;
    localparam reg_data_t fixed_e0_val   = 8'hD0;
    localparam reg_data_t fixed_f9_val   = 8'h00;
    // hpd and monitor sense interrupts enabled, then their flags cleared
    localparam reg_data_t int_enable_val = 8'hC0;
    localparam reg_data_t int_clear_val  = 8'hC0;

    // init: 24 bit rgb input, 44.1 kHz i2s audio
    localparam reg_data_t input_id_val    = 8'h00;
    localparam reg_data_t output_fmt_val  = 8'h30;  // 8-bit 4:4:4 output
    localparam reg_data_t avi_info_val    = 8'h00;
    localparam reg_data_t csc_ctrl_val    = 8'h46;
    localparam reg_data_t hdmi_mode_val   = 8'h06;
    localparam reg_data_t clk_delay_val   = 8'h60;
    localparam reg_data_t audio_sel_val   = 8'h00;
    // audio clock regeneration n = 0x01880
    localparam reg_data_t acr_n_hi_val    = 8'h00;
    localparam reg_data_t acr_n_mid_val   = 8'h18;
    localparam reg_data_t acr_n_lo_val    = 8'h80;
    localparam reg_data_t spdif_ctrl_val  = 8'h0E;
    localparam reg_data_t i2s_ctrl_val    = 8'h05;
    localparam reg_data_t i2s_width_val   = 8'h10;

endpackage
